// File: hw/cp0_pkg.sv
package cp0_pkg;

    typedef enum logic [2:0] {
        OP_MTC0,
        OP_MFC0,
        OP_EXC,
        OP_ERET,
        OP_TLBP,
        OP_TLBR,
        OP_TLBWI
    } cp0_op_e;

    // Address is register number times eight plus select
    localparam logic [7:0] ADDR_INDEX    = {5'd0, 3'd0};
    localparam logic [7:0] ADDR_ENTRYLO0 = {5'd2, 3'd0};
    localparam logic [7:0] ADDR_ENTRYLO1 = {5'd3, 3'd0};
    localparam logic [7:0] ADDR_BADVADDR = {5'd8, 3'd0};
    localparam logic [7:0] ADDR_COUNT    = {5'd9, 3'd0};
    localparam logic [7:0] ADDR_ENTRYHI  = {5'd10, 3'd0};
    localparam logic [7:0] ADDR_COMPARE  = {5'd11, 3'd0};
    localparam logic [7:0] ADDR_STATUS   = {5'd12, 3'd0};
    localparam logic [7:0] ADDR_CAUSE    = {5'd13, 3'd0};
    localparam logic [7:0] ADDR_EPC      = {5'd14, 3'd0};
    localparam logic [7:0] ADDR_CONFIG   = {5'd16, 3'd0};
    localparam logic [7:0] ADDR_CONFIG1  = {5'd16, 3'd1};

    localparam logic [31:0] STATUS_RESET  = 32'h0040_0000;
    localparam logic [31:0] CONFIG_RESET  = {1'b1, 15'd0, 1'b0, 2'd0, 3'd0, 3'd1, 4'd0, 3'd2};
    localparam logic [31:0] CONFIG1_VALUE = {1'b0, 6'd15, 3'd2, 3'd3, 3'd1, 3'd2, 3'd3, 3'd1, 7'd0};

    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_IM_LO = 8;
    localparam int CAUSE_EXC_LO = 2;
    localparam int CAUSE_IP_LO  = 8;
    localparam int CAUSE_TI     = 30;
    localparam int CAUSE_BD     = 31;

    // Bit n set means exception code n loads BadVAddr (codes 1 to 5)
    localparam logic [31:0] BADV_CODES = 32'h0000_003e;
    // TLB modified and refill codes 1 to 3 also load EntryHi VPN2
    localparam logic [31:0] TLB_CODES  = 32'h0000_000e;

endpackage

// File: hw/cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [5:0] interrupt,
    output logic       has_int,
    reg_access_if.regs ra,
    cp0_tlb_if.regs    tlb
);

    localparam logic [31:0] INDEX_MASK = 32'(TLB_ENTRIES - 1);

    logic [31:0] index;
    logic [31:0] entrylo0;
    logic [31:0] entrylo1;
    logic [31:0] entryhi;
    logic [31:0] badvaddr;
    logic [32:0] count;
    logic [31:0] compare;
    logic [31:0] status;
    logic [31:0] cause;
    logic [31:0] epc;
    logic [31:0] cfg;

    assign tlb.index    = index;
    assign tlb.entryhi  = entryhi;
    assign tlb.entrylo0 = entrylo0;
    assign tlb.entrylo1 = entrylo1;

    assign has_int = (|(cause[cp0_pkg::CAUSE_IP_LO +: 8] & status[cp0_pkg::STATUS_IM_LO +: 8]))
                     && status[cp0_pkg::STATUS_IE] && !status[cp0_pkg::STATUS_EXL];

    always_ff @(posedge clk) begin
        if (rst) begin
            index   <= '0;
            count   <= '0;
            compare <= '0;
            status  <= cp0_pkg::STATUS_RESET;
            cause   <= '0;
            cfg     <= cp0_pkg::CONFIG_RESET;
        end else begin
            // Count is the upper 32 bits, so it moves every second cycle
            count <= count + 33'd1;

            // Hardware lines land in the pending byte one cycle late
            cause[cp0_pkg::CAUSE_IP_LO + 2 +: 6] <=
                {cause[cp0_pkg::CAUSE_TI] | interrupt[5], interrupt[4:0]};

            if (compare != 32'd0 && count[32:1] == compare) begin
                cause[cp0_pkg::CAUSE_TI] <= 1'b1;
            end

            if (tlb.done) begin
                case (tlb.cmd)
                    tlb_pkg::TLB_PROBE: begin
                        index <= tlb.probe_index;
                    end
                    tlb_pkg::TLB_READ: begin
                        entryhi  <= tlb.rd_entryhi;
                        entrylo0 <= tlb.rd_entrylo0;
                        entrylo1 <= tlb.rd_entrylo1;
                    end
                    default: begin
                    end
                endcase
            end

            if (ra.exc_en) begin
                status[cp0_pkg::STATUS_EXL]       <= 1'b1;
                cause[cp0_pkg::CAUSE_EXC_LO +: 5] <= ra.exccode;
                cause[cp0_pkg::CAUSE_BD]          <= ra.bd;
                epc                               <= ra.epc_in;
                if (cp0_pkg::BADV_CODES[ra.exccode]) begin
                    badvaddr <= ra.badvaddr;
                end
                if (cp0_pkg::TLB_CODES[ra.exccode]) begin
                    entryhi[31:13] <= ra.badvaddr[31:13];
                end
            end

            if (ra.eret_en) begin
                status[cp0_pkg::STATUS_EXL] <= 1'b0;
            end

            if (ra.wr_en) begin
                case (ra.addr)
                    cp0_pkg::ADDR_INDEX: begin
                        index <= ra.wdata & INDEX_MASK;
                    end
                    cp0_pkg::ADDR_ENTRYLO0: begin
                        entrylo0 <= {6'h0, ra.wdata[25:0]};
                    end
                    cp0_pkg::ADDR_ENTRYLO1: begin
                        entrylo1 <= {6'h0, ra.wdata[25:0]};
                    end
                    cp0_pkg::ADDR_COUNT: begin
                        count <= {ra.wdata, 1'b0};
                    end
                    cp0_pkg::ADDR_ENTRYHI: begin
                        entryhi <= {ra.wdata[31:13], 5'h0, ra.wdata[7:0]};
                    end
                    cp0_pkg::ADDR_COMPARE: begin
                        // Writing Compare acknowledges the timer interrupt
                        compare                  <= ra.wdata;
                        cause[cp0_pkg::CAUSE_TI] <= 1'b0;
                    end
                    cp0_pkg::ADDR_STATUS: begin
                        status[cp0_pkg::STATUS_IM_LO +: 8] <= ra.wdata[cp0_pkg::STATUS_IM_LO +: 8];
                        status[cp0_pkg::STATUS_EXL]        <= ra.wdata[cp0_pkg::STATUS_EXL];
                        status[cp0_pkg::STATUS_IE]         <= ra.wdata[cp0_pkg::STATUS_IE];
                    end
                    cp0_pkg::ADDR_CAUSE: begin
                        cause[cp0_pkg::CAUSE_IP_LO +: 2] <= ra.wdata[cp0_pkg::CAUSE_IP_LO +: 2];
                    end
                    cp0_pkg::ADDR_EPC: begin
                        epc <= ra.wdata;
                    end
                    cp0_pkg::ADDR_CONFIG: begin
                        cfg[2:0] <= ra.wdata[2:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (ra.addr)
            cp0_pkg::ADDR_INDEX:    ra.rdata = index;
            cp0_pkg::ADDR_ENTRYLO0: ra.rdata = entrylo0;
            cp0_pkg::ADDR_ENTRYLO1: ra.rdata = entrylo1;
            cp0_pkg::ADDR_BADVADDR: ra.rdata = badvaddr;
            cp0_pkg::ADDR_COUNT:    ra.rdata = count[32:1];
            cp0_pkg::ADDR_ENTRYHI:  ra.rdata = entryhi;
            cp0_pkg::ADDR_COMPARE:  ra.rdata = compare;
            cp0_pkg::ADDR_STATUS:   ra.rdata = status;
            cp0_pkg::ADDR_CAUSE:    ra.rdata = cause;
            cp0_pkg::ADDR_EPC:      ra.rdata = epc;
            cp0_pkg::ADDR_CONFIG:   ra.rdata = cfg;
            cp0_pkg::ADDR_CONFIG1:  ra.rdata = cp0_pkg::CONFIG1_VALUE;
            default:                ra.rdata = 32'd0;
        endcase
    end

endmodule

// File: hw/cp0_tlb_if.sv
`timescale 1ns/1ps

interface cp0_tlb_if;

    tlb_pkg::tlb_cmd_e cmd;
    logic              cmd_valid;

    // Current register contents seen by the TLB
    logic [31:0] index;
    logic [31:0] entryhi;
    logic [31:0] entrylo0;
    logic [31:0] entrylo1;

    logic        done;
    logic [31:0] probe_index;
    logic [31:0] rd_entryhi;
    logic [31:0] rd_entrylo0;
    logic [31:0] rd_entrylo1;

    modport ctrl (output cmd, cmd_valid, input done);

    modport regs (
        input  cmd, done, probe_index, rd_entryhi, rd_entrylo0, rd_entrylo1,
        output index, entryhi, entrylo0, entrylo1
    );

    modport tlb (
        input  cmd, cmd_valid, index, entryhi, entrylo0, entrylo1,
        output done, probe_index, rd_entryhi, rd_entrylo0, rd_entrylo1
    );

endinterface

// File: hw/cp0_unit.sv
`timescale 1ns/1ps

module cp0_unit #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             req,
    input  cp0_pkg::cp0_op_e op,
    input  logic [7:0]       addr,
    input  logic [31:0]      wdata,
    input  logic [4:0]       exccode,
    input  logic             bd,
    input  logic [31:0]      badvaddr,
    input  logic [5:0]       interrupt,
    output logic             ack,
    output logic [31:0]      rdata,
    output logic             has_int
);

    reg_access_if reg_bus ();
    cp0_tlb_if    tlb_bus ();

    priv_ctrl i_ctrl (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .op       (op),
        .addr     (addr),
        .wdata    (wdata),
        .exccode  (exccode),
        .bd       (bd),
        .badvaddr (badvaddr),
        .ack      (ack),
        .rdata    (rdata),
        .ra       (reg_bus.ctrl),
        .tlb      (tlb_bus.ctrl)
    );

    cp0_regs #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) i_regs (
        .clk       (clk),
        .rst       (rst),
        .interrupt (interrupt),
        .has_int   (has_int),
        .ra        (reg_bus.regs),
        .tlb       (tlb_bus.regs)
    );

    tlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) i_tlb (
        .clk (clk),
        .rst (rst),
        .tlb (tlb_bus.tlb)
    );

endmodule

// File: hw/priv_ctrl.sv
`timescale 1ns/1ps

module priv_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             req,
    input  cp0_pkg::cp0_op_e op,
    input  logic [7:0]       addr,
    input  logic [31:0]      wdata,
    input  logic [4:0]       exccode,
    input  logic             bd,
    input  logic [31:0]      badvaddr,
    output logic             ack,
    output logic [31:0]      rdata,
    reg_access_if.ctrl       ra,
    cp0_tlb_if.ctrl          tlb
);

    typedef enum logic [1:0] {IDLE, EXEC, TLB_WAIT, DONE} state_e;

    state_e state;
    logic   is_tlb_op;

    assign is_tlb_op = (op == cp0_pkg::OP_TLBP) || (op == cp0_pkg::OP_TLBR) ||
                       (op == cp0_pkg::OP_TLBWI);

    // ERET reads EPC so the return address comes back on rdata
    assign ra.addr     = (op == cp0_pkg::OP_ERET) ? cp0_pkg::ADDR_EPC : addr;
    assign ra.wdata    = wdata;
    assign ra.exccode  = exccode;
    assign ra.bd       = bd;
    assign ra.epc_in   = wdata;
    assign ra.badvaddr = badvaddr;

    assign ra.wr_en   = (state == EXEC) && (op == cp0_pkg::OP_MTC0);
    assign ra.exc_en  = (state == EXEC) && (op == cp0_pkg::OP_EXC);
    assign ra.eret_en = (state == EXEC) && (op == cp0_pkg::OP_ERET);

    assign tlb.cmd_valid = (state == EXEC) && is_tlb_op;

    always_comb begin
        case (op)
            cp0_pkg::OP_TLBP: tlb.cmd = tlb_pkg::TLB_PROBE;
            cp0_pkg::OP_TLBR: tlb.cmd = tlb_pkg::TLB_READ;
            default:          tlb.cmd = tlb_pkg::TLB_WRITE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == EXEC) begin
            rdata <= (op == cp0_pkg::OP_MFC0 || op == cp0_pkg::OP_ERET) ? ra.rdata : 32'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    state <= is_tlb_op ? TLB_WAIT : DONE;
                end
                TLB_WAIT: begin
                    if (tlb.done) begin
                        state <= DONE;
                    end
                end
                default: begin
                    // Hold ack until the requester drops req
                    if (!ack) begin
                        ack <= 1'b1;
                    end else if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: hw/reg_access_if.sv
`timescale 1ns/1ps

interface reg_access_if;

    logic        wr_en;
    logic [7:0]  addr;
    logic [31:0] wdata;

    // Exception entry
    logic        exc_en;
    logic [4:0]  exccode;
    logic        bd;
    logic [31:0] epc_in;
    logic [31:0] badvaddr;

    logic        eret_en;
    logic [31:0] rdata;

    modport ctrl (
        output wr_en, addr, wdata, exc_en, exccode, bd, epc_in, badvaddr, eret_en,
        input  rdata
    );

    modport regs (
        input  wr_en, addr, wdata, exc_en, exccode, bd, epc_in, badvaddr, eret_en,
        output rdata
    );

endinterface

// File: hw/tlb.sv
`timescale 1ns/1ps

module tlb #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic   clk,
    input  logic   rst,
    cp0_tlb_if.tlb tlb
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    tlb_pkg::tlb_entry_t entries [TLB_ENTRIES];
    tlb_pkg::tlb_entry_t sel;
    logic [IDX_W-1:0]    idx;
    logic [IDX_W-1:0]    hit_idx;
    logic                hit;

    assign idx = tlb.index[IDX_W-1:0];
    assign sel = entries[idx];

    // Scan downwards so the lowest matching entry wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entries[i].vpn2 == tlb.entryhi[31:13] &&
                (entries[i].g || entries[i].asid == tlb.entryhi[7:0])) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tlb.done <= 1'b0;
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else begin
            tlb.done <= tlb.cmd_valid;
            if (tlb.cmd_valid) begin
                case (tlb.cmd)
                    tlb_pkg::TLB_PROBE: begin
                        tlb.probe_index <= hit ? 32'(hit_idx)
                                               : (32'd1 << tlb_pkg::PROBE_MISS_BIT);
                    end
                    tlb_pkg::TLB_READ: begin
                        tlb.rd_entryhi  <= {sel.vpn2, 5'h0, sel.asid};
                        tlb.rd_entrylo0 <= {6'h0, sel.lo0, sel.g};
                        tlb.rd_entrylo1 <= {6'h0, sel.lo1, sel.g};
                    end
                    default: begin
                        // An entry is global only when both halves say so
                        entries[idx] <= {tlb.entryhi[31:13], tlb.entryhi[7:0],
                                         tlb.entrylo0[0] & tlb.entrylo1[0],
                                         tlb.entrylo0[25:1], tlb.entrylo1[25:1]};
                    end
                endcase
            end
        end
    end

endmodule

// File: hw/tlb_pkg.sv
package tlb_pkg;

    typedef enum logic [1:0] {
        TLB_PROBE,
        TLB_READ,
        TLB_WRITE
    } tlb_cmd_e;

    // lo0 and lo1 hold EntryLo bits 25..1, that is PFN, C, D and V
    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [24:0] lo0;
        logic [24:0] lo1;
    } tlb_entry_t;

    localparam int PROBE_MISS_BIT = 31;

endpackage

// File: run_sim.sh
#!/bin/bash
# Build and run the CP0 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f sources.f --top-module tb_cp0_unit -o sim_cp0
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_cp0 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

// File: sources.f
+incdir+verif
hw/cp0_pkg.sv
hw/tlb_pkg.sv
hw/reg_access_if.sv
hw/cp0_tlb_if.sv
hw/cp0_regs.sv
hw/tlb.sv
hw/priv_ctrl.sv
hw/cp0_unit.sv
verif/tb_cp0_unit.sv

// File: verif/cp0_model.svh
`ifndef CP0_MODEL_SVH
`define CP0_MODEL_SVH

logic [31:0]         m_index    = 32'd0;
logic [31:0]         m_lo0;
logic [31:0]         m_lo1;
logic [31:0]         m_hi;
logic [31:0]         m_badv;
logic [31:0]         m_count    = 32'd0;
int                  m_count_at = 0;
logic [31:0]         m_compare  = 32'd0;
logic [31:0]         m_status   = cp0_pkg::STATUS_RESET;
logic [31:0]         m_epc;
logic [31:0]         m_cfg      = cp0_pkg::CONFIG_RESET;
logic [1:0]          m_ip_sw    = 2'd0;
logic                m_ti       = 1'b0;
logic                m_bd       = 1'b0;
logic [4:0]          m_code     = 5'd0;
logic [5:0]          m_pins     = 6'd0;
tlb_pkg::tlb_entry_t m_tlb [16];

function automatic logic [7:0] model_pending();
    return {m_ti | m_pins[5], m_pins[4:0], m_ip_sw};
endfunction

function automatic logic [31:0] model_read(input logic [7:0] a);
    case (a)
        cp0_pkg::ADDR_INDEX:    return m_index;
        cp0_pkg::ADDR_ENTRYLO0: return m_lo0;
        cp0_pkg::ADDR_ENTRYLO1: return m_lo1;
        cp0_pkg::ADDR_BADVADDR: return m_badv;
        // Count moves once every two cycles after the edge that wrote it
        cp0_pkg::ADDR_COUNT:    return m_count + 32'((ack_cycle - m_count_at - 1) / 2);
        cp0_pkg::ADDR_ENTRYHI:  return m_hi;
        cp0_pkg::ADDR_COMPARE:  return m_compare;
        cp0_pkg::ADDR_STATUS:   return m_status;
        cp0_pkg::ADDR_CAUSE:
            return {m_bd, m_ti, 14'd0, model_pending(), 1'b0, m_code, 2'd0};
        cp0_pkg::ADDR_EPC:      return m_epc;
        cp0_pkg::ADDR_CONFIG:   return m_cfg;
        cp0_pkg::ADDR_CONFIG1:  return cp0_pkg::CONFIG1_VALUE;
        default:                return 32'd0;
    endcase
endfunction

function automatic logic model_has_int();
    return (|(model_pending() & m_status[15:8])) && m_status[0] && !m_status[1];
endfunction

task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
        $display("Test failed");
        $fatal(1);
    end
endtask

task automatic check_int(input logic got, input logic exp);
    if (got !== exp) begin
        $display("Error: time %0t has_int got %b expected %b", $time, got, exp);
        $display("Test failed");
        $fatal(1);
    end
endtask

`endif

// File: verif/tb_cp0_unit.sv
`timescale 1ns/1ps

module tb_cp0_unit;

    localparam int NUM_REQ    = 300;
    localparam int TIMER_WAIT = 200;

    logic             clk = 1'b0;
    logic             rst;
    logic             req;
    cp0_pkg::cp0_op_e op;
    logic [7:0]       addr;
    logic [31:0]      wdata;
    logic [4:0]       exccode;
    logic             bd;
    logic [31:0]      badvaddr;
    logic [5:0]       interrupt;
    logic             ack;
    logic [31:0]      rdata;
    logic             has_int;
    integer           seed = 9170;
    int               cycle_cnt = 0;
    int               ack_cycle = 0;

    `include "cp0_model.svh"

    cp0_unit #(.TLB_ENTRIES(16)) i_dut (
        .clk(clk), .rst(rst), .req(req), .op(op), .addr(addr), .wdata(wdata),
        .exccode(exccode), .bd(bd), .badvaddr(badvaddr), .interrupt(interrupt),
        .ack(ack), .rdata(rdata), .has_int(has_int)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        #((NUM_REQ * 20 + TIMER_WAIT) * 40);
        $display("Watchdog expired before the tests completed");
        $display("Test failed");
        $fatal(1);
    end

    task automatic run_req(input cp0_pkg::cp0_op_e o, input logic [7:0] a,
                           input logic [31:0] d, input logic [4:0] code, input logic b,
                           input logic [31:0] bv, output logic [31:0] rd);
        @(posedge clk);
        req      <= 1'b1;
        op       <= o;
        addr     <= a;
        wdata    <= d;
        exccode  <= code;
        bd       <= b;
        badvaddr <= bv;
        @(negedge clk);
        while (!ack) @(negedge clk);
        ack_cycle = cycle_cnt;
        rd = rdata;
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
        logic [31:0] rd;
        run_req(cp0_pkg::OP_MTC0, a, d, 5'd0, 1'b0, 32'd0, rd);
        check_data("mtc0 rdata", rd, 32'd0);
        case (a)
            cp0_pkg::ADDR_INDEX:    m_index = d & 32'h0000_000f;
            cp0_pkg::ADDR_ENTRYLO0: m_lo0 = {6'd0, d[25:0]};
            cp0_pkg::ADDR_ENTRYLO1: m_lo1 = {6'd0, d[25:0]};
            cp0_pkg::ADDR_ENTRYHI:  m_hi = {d[31:13], 5'd0, d[7:0]};
            cp0_pkg::ADDR_COUNT: begin
                m_count = d;
                m_count_at = ack_cycle;
            end
            cp0_pkg::ADDR_COMPARE: begin
                m_compare = d;
                m_ti = 1'b0;
            end
            cp0_pkg::ADDR_STATUS:   m_status = (m_status & ~32'h0000_ff03) | (d & 32'h0000_ff03);
            cp0_pkg::ADDR_CAUSE:    m_ip_sw = d[9:8];
            cp0_pkg::ADDR_EPC:      m_epc = d;
            cp0_pkg::ADDR_CONFIG:   m_cfg[2:0] = d[2:0];
            default: begin
            end
        endcase
    endtask

    task automatic read_and_check(input logic [7:0] a, input string name);
        logic [31:0] rd;
        run_req(cp0_pkg::OP_MFC0, a, 32'd0, 5'd0, 1'b0, 32'd0, rd);
        check_data(name, rd, model_read(a));
    endtask

    task automatic tlb_op(input cp0_pkg::cp0_op_e o);
        logic [31:0] rd;
        tlb_pkg::tlb_entry_t e;
        run_req(o, 8'd0, 32'd0, 5'd0, 1'b0, 32'd0, rd);
        check_data("rdata", rd, 32'd0);
        if (o == cp0_pkg::OP_TLBWI) begin
            e = {m_hi[31:13], m_hi[7:0], m_lo0[0] & m_lo1[0], m_lo0[25:1], m_lo1[25:1]};
            m_tlb[m_index[3:0]] = e;
        end else if (o == cp0_pkg::OP_TLBR) begin
            e = m_tlb[m_index[3:0]];
            m_hi  = {e.vpn2, 5'd0, e.asid};
            m_lo0 = {6'd0, e.lo0, e.g};
            m_lo1 = {6'd0, e.lo1, e.g};
        end else begin
            m_index = 32'h8000_0000;
            for (int i = 15; i >= 0; i--) begin
                if (m_tlb[i].vpn2 == m_hi[31:13] &&
                    (m_tlb[i].g || m_tlb[i].asid == m_hi[7:0])) begin
                    m_index = i;
                end
            end
        end
    endtask

    initial begin
        logic [7:0]  wr_addrs [10];
        logic [31:0] r;
        logic [31:0] v;
        logic [31:0] rd;
        logic [31:0] epc;
        tlb_pkg::tlb_entry_t e;
        wr_addrs = '{cp0_pkg::ADDR_INDEX, cp0_pkg::ADDR_ENTRYLO0, cp0_pkg::ADDR_ENTRYLO1,
                     cp0_pkg::ADDR_ENTRYHI, cp0_pkg::ADDR_COUNT, cp0_pkg::ADDR_COMPARE,
                     cp0_pkg::ADDR_STATUS, cp0_pkg::ADDR_CAUSE, cp0_pkg::ADDR_EPC,
                     cp0_pkg::ADDR_CONFIG};
        for (int i = 0; i < 16; i++) m_tlb[i] = '0;
        rst = 1'b1;
        req = 1'b0;
        op = cp0_pkg::OP_MFC0;
        addr = 8'd0;
        wdata = 32'd0;
        exccode = 5'd0;
        bd = 1'b0;
        badvaddr = 32'd0;
        interrupt = 6'd0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Register contents straight out of reset
        read_and_check(cp0_pkg::ADDR_INDEX, "Index");
        read_and_check(cp0_pkg::ADDR_STATUS, "Status");
        read_and_check(cp0_pkg::ADDR_CAUSE, "Cause");
        read_and_check(cp0_pkg::ADDR_CONFIG, "Config");
        read_and_check(cp0_pkg::ADDR_COMPARE, "Compare");
        check_int(has_int, 1'b0);

        // Masked write and read-back of every writable register
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < 10; j++) begin
                r = $random(seed);
                write_reg(wr_addrs[j], r);
                read_and_check(wr_addrs[j], "mfc0 readback");
            end
        end
        write_reg(cp0_pkg::ADDR_COMPARE, 32'd0);
        read_and_check(cp0_pkg::ADDR_CONFIG1, "Config1");
        for (int k = 0; k < 4; k++) begin
            r = $random(seed);
            if (r[7:0] != cp0_pkg::ADDR_COUNT) read_and_check(r[7:0], "unmapped read");
        end

        // Exception entry with an address-error code first and a TLB code second
        for (int k = 0; k < 8; k++) begin
            r = $random(seed);
            v = $random(seed);
            if (k == 0) r[4:0] = 5'd4;
            if (k == 1) r[4:0] = 5'd2;
            epc = $random(seed);
            run_req(cp0_pkg::OP_EXC, 8'd0, epc, r[4:0], r[5], v, rd);
            check_data("exc rdata", rd, 32'd0);
            m_status[1] = 1'b1;
            m_code = r[4:0];
            m_bd = r[5];
            m_epc = epc;
            if (r[4:0] >= 5'd1 && r[4:0] <= 5'd5) m_badv = v;
            if (r[4:0] >= 5'd1 && r[4:0] <= 5'd3) m_hi[31:13] = v[31:13];
            read_and_check(cp0_pkg::ADDR_STATUS, "Status");
            read_and_check(cp0_pkg::ADDR_CAUSE, "Cause");
            read_and_check(cp0_pkg::ADDR_EPC, "EPC");
            read_and_check(cp0_pkg::ADDR_BADVADDR, "BadVAddr");
            read_and_check(cp0_pkg::ADDR_ENTRYHI, "EntryHi");
        end

        // Exception return
        for (int k = 0; k < 2; k++) begin
            run_req(cp0_pkg::OP_ERET, 8'd0, 32'd0, 5'd0, 1'b0, 32'd0, rd);
            check_data("eret rdata", rd, m_epc);
            m_status[1] = 1'b0;
            read_and_check(cp0_pkg::ADDR_STATUS, "Status");
        end

        // Indexed TLB writes then reads
        for (int k = 0; k < 8; k++) begin
            write_reg(cp0_pkg::ADDR_INDEX, $random(seed));
            write_reg(cp0_pkg::ADDR_ENTRYHI, $random(seed));
            write_reg(cp0_pkg::ADDR_ENTRYLO0, $random(seed));
            write_reg(cp0_pkg::ADDR_ENTRYLO1, $random(seed));
            tlb_op(cp0_pkg::OP_TLBWI);
        end
        for (int k = 0; k < 8; k++) begin
            write_reg(cp0_pkg::ADDR_INDEX, $random(seed));
            tlb_op(cp0_pkg::OP_TLBR);
            read_and_check(cp0_pkg::ADDR_ENTRYHI, "EntryHi");
            read_and_check(cp0_pkg::ADDR_ENTRYLO0, "EntryLo0");
            read_and_check(cp0_pkg::ADDR_ENTRYLO1, "EntryLo1");
        end

        // Probes that hit exactly, hit with another ASID, or use random tags
        for (int k = 0; k < 16; k++) begin
            r = $random(seed);
            e = m_tlb[r[3:0]];
            v = $random(seed);
            if (k % 3 == 0) v = {e.vpn2, 5'd0, e.asid};
            else if (k % 3 == 1) v = {e.vpn2, 5'd0, v[7:0]};
            write_reg(cp0_pkg::ADDR_ENTRYHI, v);
            tlb_op(cp0_pkg::OP_TLBP);
            read_and_check(cp0_pkg::ADDR_INDEX, "Index");
        end

        // Interrupt rule over random masks, enables and pins
        for (int k = 0; k < 12; k++) begin
            write_reg(cp0_pkg::ADDR_STATUS, $random(seed));
            write_reg(cp0_pkg::ADDR_CAUSE, $random(seed));
            r = $random(seed);
            @(posedge clk);
            interrupt <= r[5:0];
            m_pins = r[5:0];
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_int(has_int, model_has_int());
        end

        // Timer interrupt
        @(posedge clk);
        interrupt <= 6'd0;
        m_pins = 6'd0;
        write_reg(cp0_pkg::ADDR_STATUS, 32'd0);
        write_reg(cp0_pkg::ADDR_CAUSE, 32'd0);
        write_reg(cp0_pkg::ADDR_COUNT, 32'd0);
        write_reg(cp0_pkg::ADDR_COMPARE, 32'd20);
        write_reg(cp0_pkg::ADDR_STATUS, 32'h0000_8001);
        for (int c = 0; c < TIMER_WAIT && !has_int; c++) @(negedge clk);
        if (!has_int) begin
            $display("Timer interrupt did not rise after the Compare match");
            $display("Test failed");
            $fatal(1);
        end else begin
            m_ti = 1'b1;
            read_and_check(cp0_pkg::ADDR_CAUSE, "Cause");
            $display("Test passed");
            $finish;
        end
    end

endmodule
